// File: Makefile
SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := tb_exec_stage
FLIST   := exec_stage.f
OBJ_DIR := obj_dir
LOG     := sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) hdl/exec_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG) || \
	    ! grep -q "Simulation finished: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_exec_stage.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module tb_exec_stage;

    localparam int N_ALU = 200;
    localparam int N_ST  = 48;
    localparam int N_LD  = 48;
    localparam int N_MIX = 300;
    // Four cycles per op at worst plus reset and drain margin
    localparam int MAX_CYC = 4 * (N_ALU + N_ST + N_LD + N_MIX) + 100;
    localparam int BA_W = $clog2(4 * `DMEM_WORDS);

    // Expected write-back entry
    typedef struct packed {
        int unsigned       cyc;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  data;
    } exp_t;

    logic                    clk;
    logic                    rst_n_i;
    logic                    valid_i;
    core_pkg::fu_t           fu_i;
    core_pkg::fu_op_u        op_i;
    logic [`XLEN-1:0]        rs1_i;
    logic [`XLEN-1:0]        rs2_i;
    logic [`XLEN-1:0]        imm_i;
    logic [`REG_W-1:0]       rd_i;
    core_pkg::fu_vec_t       ready_o;
    logic [`NR_WB_PORTS-1:0] wb_valid_o;
    logic [`REG_W-1:0]       wb_rd_o [`NR_WB_PORTS];
    logic [`XLEN-1:0]        wb_data_o [`NR_WB_PORTS];

    // Byte image of the data RAM
    logic [7:0]  shadow [4*`DMEM_WORDS];
    exp_t        alu_q[$];
    exp_t        lsu_q[$];
    int unsigned cyc = 0;
    int unsigned lsu_acc_cyc = 0;
    int unsigned n_dual = 0;
    int          data_errs = 0;
    int          rd_errs = 0;
    int          timing_errs = 0;
    int          other_errs = 0;

    exec_stage dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .fu_i       (fu_i),
        .op_i       (op_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .imm_i      (imm_i),
        .rd_i       (rd_i),
        .ready_o    (ready_o),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Rising edges seen so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [`XLEN-1:0] alu_ref(input core_pkg::alu_op_t op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] r;
        logic             lt;
        // Signed less-than from the sign bits or an unsigned compare when they agree
        lt = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
        case (op)
            core_pkg::ADD: r = a + b;
            core_pkg::SUB: r = a - b;
            core_pkg::AND: r = a & b;
            core_pkg::OR:  r = a | b;
            core_pkg::XOR: r = a ^ b;
            core_pkg::SLL: r = a << b[4:0];
            core_pkg::SRL: r = a >> b[4:0];
            default:       r = {{(`XLEN-1){1'b0}}, lt};
        endcase
        return r;
    endfunction

    function automatic logic [`XLEN-1:0] load_ref(input logic [BA_W-1:0] addr,
                                                  input logic [1:0] size,
                                                  input logic uns);
        logic [7:0]       b;
        logic [15:0]      h;
        logic [`XLEN-1:0] v;
        b = shadow[addr];
        h = {shadow[addr+1], shadow[addr]};
        case (size)
            2'd0:    v = uns ? {24'b0, b} : {{24{b[7]}}, b};
            2'd1:    v = uns ? {16'b0, h} : {{16{h[15]}}, h};
            default: v = {shadow[addr+3], shadow[addr+2], h};
        endcase
        return v;
    endfunction

    // Little-endian update from the low bytes of the store data
    task automatic shadow_store(input logic [BA_W-1:0] addr, input logic [1:0] size,
                                input logic [`XLEN-1:0] data);
        shadow[addr] = data[7:0];
        if (size != 2'd0) begin
            shadow[addr+1] = data[15:8];
        end
        if (size == 2'd2) begin
            shadow[addr+2] = data[23:16];
            shadow[addr+3] = data[31:24];
        end
    endtask

    // Drive on the falling edge and hold until the unit is ready
    task automatic issue(input core_pkg::fu_t fu, input core_pkg::fu_op_u op,
                         input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                         input logic [`XLEN-1:0] imm, input logic [`REG_W-1:0] rd);
        exp_t             e;
        logic [`XLEN-1:0] ea;
        valid_i = 1'b1;
        fu_i    = fu;
        op_i    = op;
        rs1_i   = a;
        rs2_i   = b;
        imm_i   = imm;
        rd_i    = rd;
        while (!ready_o[fu]) begin
            @(negedge clk);
        end
        // Accepted on the next rising edge, which is edge cyc + 1
        e.rd = rd;
        if (fu == core_pkg::FU_ALU) begin
            e.cyc  = cyc + 1;
            e.data = alu_ref(op.alu.alu_op, a, op.alu.use_imm ? imm : b);
            alu_q.push_back(e);
        end else begin
            ea = a + imm;
            lsu_acc_cyc = cyc + 1;
            if (op.lsu.is_store) begin
                shadow_store(ea[BA_W-1:0], op.lsu.size, b);
            end else begin
                e.cyc  = cyc + 2;
                e.data = load_ref(ea[BA_W-1:0], op.lsu.size, op.lsu.is_unsigned);
                lsu_q.push_back(e);
            end
        end
        @(negedge clk);
        valid_i = 1'b0;
    endtask

    task automatic issue_alu();
        core_pkg::fu_op_u op;
        op.alu.use_imm = 1'($urandom_range(0, 1));
        op.alu.alu_op  = core_pkg::alu_op_t'($urandom_range(0, 7));
        issue(core_pkg::FU_ALU, op, $urandom, $urandom, $urandom, `REG_W'($urandom));
    endtask

    // Aligned access within the first words of the RAM from a random base plus offset
    task automatic lsu_op(input logic is_store, input logic [1:0] size, input logic uns,
                          input int words);
        core_pkg::fu_op_u op;
        logic [BA_W-1:0]  addr;
        logic [`XLEN-1:0] base;
        addr = BA_W'($urandom_range(0, 4 * words - 1));
        if (size == 2'd1) begin
            addr[0] = 1'b0;
        end else if (size == 2'd2) begin
            addr[1:0] = 2'b00;
        end
        base = $urandom;
        op.lsu.is_store    = is_store;
        op.lsu.is_unsigned = uns;
        op.lsu.size        = core_pkg::lsu_size_t'(size);
        issue(core_pkg::FU_LSU, op, base, $urandom, `XLEN'(addr) - base, `REG_W'($urandom));
    endtask

    task automatic check_port(input int p, input exp_t e);
        assert (wb_rd_o[p] == e.rd) else begin
            $display("** Error at %0t: wb_rd_o[%0d] expected %0d got %0d",
                     $time, p, e.rd, wb_rd_o[p]);
            rd_errs++;
        end
        assert (wb_data_o[p] == e.data) else begin
            $display("** Error at %0t: wb_data_o[%0d] expected %h got %h",
                     $time, p, e.data, wb_data_o[p]);
            data_errs++;
        end
        assert (cyc == e.cyc) else begin
            $display("** Error at %0t: wb_valid_o[%0d] cycle expected %0d got %0d",
                     $time, p, e.cyc, cyc);
            timing_errs++;
        end
    endtask

    // Compare on the falling edge where all DUT outputs are settled
    always @(negedge clk) begin
        assert (!ready_o[core_pkg::FU_MUL] && !ready_o[core_pkg::FU_BR]) else begin
            $display("** Error at %0t: ready_o[3:2] expected 00 got %b%b", $time,
                     ready_o[core_pkg::FU_BR], ready_o[core_pkg::FU_MUL]);
            other_errs++;
        end
        if (rst_n_i) begin
            assert (ready_o[core_pkg::FU_ALU]) else begin
                $display("** Error at %0t: ready_o[FU_ALU] expected 1 got %b",
                         $time, ready_o[core_pkg::FU_ALU]);
                other_errs++;
            end
            // Busy only in the cycle after an LSU acceptance
            assert (ready_o[core_pkg::FU_LSU] == (cyc != lsu_acc_cyc)) else begin
                $display("** Error at %0t: ready_o[FU_LSU] expected %0b got %0b",
                         $time, cyc != lsu_acc_cyc, ready_o[core_pkg::FU_LSU]);
                timing_errs++;
            end
            if (wb_valid_o[0]) begin
                if (alu_q.size() == 0) begin
                    $display("[%0t] Result on port 0 with no ALU op outstanding", $time);
                    other_errs++;
                end else begin
                    check_port(0, alu_q.pop_front());
                end
            end
            if (wb_valid_o[1]) begin
                if (lsu_q.size() == 0) begin
                    $display("[%0t] Result on port 1 with no load outstanding", $time);
                    other_errs++;
                end else begin
                    check_port(1, lsu_q.pop_front());
                end
            end
            if (&wb_valid_o) begin
                n_dual++;
            end
        end
    end

    initial begin
        while (cyc < MAX_CYC) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, results still outstanding", cyc);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(62));
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        fu_i    = core_pkg::FU_ALU;
        op_i    = '0;
        rs1_i   = '0;
        rs2_i   = '0;
        imm_i   = '0;
        rd_i    = '0;
        for (int i = 0; i < 4 * `DMEM_WORDS; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        assert (wb_valid_o == '0) else begin
            $display("** Error at %0t: wb_valid_o expected 0 got %b", $time, wb_valid_o);
            other_errs++;
        end
        // Back-to-back ALU stream
        repeat (N_ALU) issue_alu();
        // Stores of every size over a small region and then every load flavor
        for (int i = 0; i < N_ST; i++) begin
            lsu_op(1'b1, 2'(i % 3), 1'b0, 8);
        end
        for (int s = 0; s < 3; s++) begin
            for (int u = 0; u < 2; u++) begin
                repeat (N_LD / 6) lsu_op(1'b0, 2'(s), 1'(u), 8);
            end
        end
        // Interleaved traffic on both units
        repeat (N_MIX) begin
            if ($urandom_range(0, 1) != 0) begin
                issue_alu();
            end else begin
                lsu_op(1'($urandom_range(0, 1)), 2'($urandom_range(0, 2)),
                       1'($urandom_range(0, 1)), 8);
            end
        end
        // Longest latency is two cycles after acceptance
        for (int i = 0; i < 4 && (alu_q.size() + lsu_q.size()) != 0; i++) begin
            @(negedge clk);
        end
        assert (alu_q.size() == 0 && lsu_q.size() == 0) else begin
            $display("Results missing at end: %0d ALU, %0d load",
                     alu_q.size(), lsu_q.size());
            other_errs++;
        end
        assert (n_dual > 0) else begin
            $display("Ports 0 and 1 never returned results in the same cycle");
            other_errs++;
        end
        $display("Errors: data %0d, rd %0d, timing %0d, other %0d",
                 data_errs, rd_errs, timing_errs, other_errs);
        if (data_errs + rd_errs + timing_errs + other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: exec_stage.f
+incdir+hdl
hdl/core_pkg.sv
hdl/fu_alu.sv
hdl/fu_lsu.sv
hdl/data_ram.sv
hdl/fus.sv
hdl/exec_stage.sv
dv/tb_exec_stage.sv

// File: hdl/core_pkg.sv
`include "exec_cfg.svh"

package core_pkg;

    // Unit selector carried with each issued instruction
    typedef enum logic [1:0] {
        FU_ALU,
        FU_LSU,
        FU_MUL,
        FU_BR
    } fu_t;

    // ALU operations, all eight codes used
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_t;

    // Memory access size, code 3 unused
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } lsu_size_t;

    // ALU view of the op field
    typedef struct packed {
        logic    use_imm;
        alu_op_t alu_op;
    } alu_view_t;

    // LSU view of the same four bits
    typedef struct packed {
        logic      is_store;
        logic      is_unsigned;
        lsu_size_t size;
    } lsu_view_t;

    // Op field, meaning depends on the target unit
    typedef union packed {
        alu_view_t alu;
        lsu_view_t lsu;
    } fu_op_u;

    // One bit per unit slot
    typedef logic [`NB_FU-1:0] fu_vec_t;

endpackage

// File: hdl/data_ram.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module data_ram (
    input  logic                clk,
    input  logic                req_i,
    input  logic                we_i,
    input  logic [3:0]          be_i,
    input  logic [`XLEN-3:0]    addr_i,
    input  logic [`XLEN-1:0]    wdata_i,
    output logic [`XLEN-1:0]    rdata_o
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    widx;

    assign widx = addr_i[AW-1:0];

    // Cleared contents at start
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Byte-masked write, registered read
    always_ff @(posedge clk) begin
        if (req_i) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) begin
                        mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[widx];
            end
        end
    end

    // Upper address bits are dropped, so they must be zero
    a_addr_range: assert property (@(posedge clk)
        req_i |-> addr_i < `DMEM_WORDS);

endmodule

// File: hdl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data path and address width
`define XLEN 32

// Unit slots addressed by the issue fu field
`define NB_FU 4

// One write-back port per real unit
`define NR_WB_PORTS 2

// Destination register index width
`define REG_W 5

// Data RAM depth in 32-bit words
`define DMEM_WORDS 64

`endif

// File: hdl/exec_stage.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  core_pkg::fu_t           fu_i,
    input  core_pkg::fu_op_u        op_i,
    input  logic [`XLEN-1:0]        rs1_i,
    input  logic [`XLEN-1:0]        rs2_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  logic [`REG_W-1:0]       rd_i,
    output core_pkg::fu_vec_t       ready_o,
    output logic [`NR_WB_PORTS-1:0] wb_valid_o,
    output logic [`REG_W-1:0]       wb_rd_o [`NR_WB_PORTS],
    output logic [`XLEN-1:0]        wb_data_o [`NR_WB_PORTS]
);

    // LSU to data RAM
    logic             mem_req;
    logic             mem_we;
    logic [3:0]       mem_be;
    logic [`XLEN-3:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;
    logic [`XLEN-1:0] mem_rdata;

    fus u_fus (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .fu_i        (fu_i),
        .op_i        (op_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .rd_i        (rd_i),
        .ready_o     (ready_o),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_be_o    (mem_be),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .req_i   (mem_req),
        .we_i    (mem_we),
        .be_i    (mem_be),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

// File: hdl/fu_alu.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module fu_alu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  core_pkg::fu_op_u    op_i,
    input  logic [`XLEN-1:0]    rs1_i,
    input  logic [`XLEN-1:0]    rs2_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`REG_W-1:0]   rd_i,
    output logic                valid_o,
    output logic [`REG_W-1:0]   rd_o,
    output logic [`XLEN-1:0]    result_o
);

    logic [`XLEN-1:0] opb;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;

    // Second operand from immediate or rs2
    assign opb = op_i.alu.use_imm ? imm_i : rs2_i;
    // Only the low five bits shift
    assign shamt = opb[4:0];

    always_comb begin
        case (op_i.alu.alu_op)
            core_pkg::ADD: alu_res = rs1_i + opb;
            core_pkg::SUB: alu_res = rs1_i - opb;
            core_pkg::AND: alu_res = rs1_i & opb;
            core_pkg::OR:  alu_res = rs1_i | opb;
            core_pkg::XOR: alu_res = rs1_i ^ opb;
            core_pkg::SLL: alu_res = rs1_i << shamt;
            core_pkg::SRL: alu_res = rs1_i >> shamt;
            // Signed compare, result is 0 or 1
            core_pkg::SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(rs1_i) < $signed(opb)};
            default:       alu_res = '0;
        endcase
    end

    // Result valid one cycle after issue
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload only moves with a valid op
    always_ff @(posedge clk) begin
        if (valid_i) begin
            rd_o     <= rd_i;
            result_o <= alu_res;
        end
    end

endmodule

// File: hdl/fu_lsu.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module fu_lsu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                valid_i,
    output logic                ready_o,
    input  core_pkg::fu_op_u    op_i,
    input  logic [`XLEN-1:0]    rs1_i,
    input  logic [`XLEN-1:0]    rs2_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`REG_W-1:0]   rd_i,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output logic [3:0]          mem_be_o,
    output logic [`XLEN-3:0]    mem_addr_o,
    output logic [`XLEN-1:0]    mem_wdata_o,
    input  logic [`XLEN-1:0]    mem_rdata_i,
    output logic                valid_o,
    output logic [`REG_W-1:0]   rd_o,
    output logic [`XLEN-1:0]    result_o
);

    logic                accept;
    logic [`XLEN-1:0]    ea;
    logic [3:0]          be;
    logic [`XLEN-1:0]    wdata;
    logic                misaligned;
    logic [1:0]          ld_off;
    core_pkg::lsu_size_t ld_size;
    logic                ld_uns;
    logic [`XLEN-1:0]    lane;

    // Busy while the request strobe is out
    assign ready_o = !mem_req_o;
    assign accept  = valid_i && ready_o;

    // Effective byte address
    assign ea = rs1_i + imm_i;

    // Byte enables and lane replication per size
    always_comb begin
        case (op_i.lsu.size)
            core_pkg::BYTE: begin
                be    = 4'b0001 << ea[1:0];
                wdata = {4{rs2_i[7:0]}};
            end
            core_pkg::HALF: begin
                be    = 4'b0011 << ea[1:0];
                wdata = {2{rs2_i[15:0]}};
            end
            core_pkg::WORD: begin
                be    = 4'b1111;
                wdata = rs2_i;
            end
            default: begin
                be    = 4'b0000;
                wdata = rs2_i;
            end
        endcase
    end

    assign misaligned = (op_i.lsu.size == core_pkg::HALF && ea[0])
                     || (op_i.lsu.size == core_pkg::WORD && ea[1:0] != 2'b00);

    // Request strobe one cycle after acceptance
    // Load result valid the cycle after that
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_req_o <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            mem_req_o <= accept;
            valid_o   <= mem_req_o && !mem_we_o;
        end
    end

    // Access payload
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_we_o    <= op_i.lsu.is_store;
            mem_be_o    <= be;
            mem_addr_o  <= ea[`XLEN-1:2];
            mem_wdata_o <= wdata;
        end
    end

    // Load context kept until the read data returns
    always_ff @(posedge clk) begin
        if (accept && !op_i.lsu.is_store) begin
            ld_off  <= ea[1:0];
            ld_size <= op_i.lsu.size;
            ld_uns  <= op_i.lsu.is_unsigned;
            rd_o    <= rd_i;
        end
    end

    // Addressed lane moved down to bit 0
    assign lane = mem_rdata_i >> {ld_off, 3'b000};

    always_comb begin
        case (ld_size)
            core_pkg::BYTE: begin
                result_o = {{(`XLEN-8){lane[7] && !ld_uns}}, lane[7:0]};
            end
            core_pkg::HALF: begin
                result_o = {{(`XLEN-16){lane[15] && !ld_uns}}, lane[15:0]};
            end
            default: begin
                result_o = mem_rdata_i;
            end
        endcase
    end

    // Sub-word and word accesses stay inside their natural boundary
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept |-> !misaligned);

    // A request stalled by the busy unit stays on the inputs until it is taken
    a_hold_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i && !ready_o |=> valid_i && $stable({op_i, rs1_i, rs2_i, imm_i, rd_i}));

endmodule

// File: hdl/fus.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module fus (
    input  logic                clk,
    input  logic                rst_n_i,
    // Issue side
    input  logic                valid_i,
    input  core_pkg::fu_t       fu_i,
    input  core_pkg::fu_op_u    op_i,
    input  logic [`XLEN-1:0]    rs1_i,
    input  logic [`XLEN-1:0]    rs2_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`REG_W-1:0]   rd_i,
    output core_pkg::fu_vec_t   ready_o,
    // Data memory, driven by the LSU
    output logic                mem_req_o,
    output logic                mem_we_o,
    output logic [3:0]          mem_be_o,
    output logic [`XLEN-3:0]    mem_addr_o,
    output logic [`XLEN-1:0]    mem_wdata_o,
    input  logic [`XLEN-1:0]    mem_rdata_i,
    // Write-back
    output logic [`NR_WB_PORTS-1:0] wb_valid_o,
    output logic [`REG_W-1:0]       wb_rd_o [`NR_WB_PORTS],
    output logic [`XLEN-1:0]        wb_data_o [`NR_WB_PORTS]
);

    // Fixed port per unit
    localparam int WB_ALU = 0;
    localparam int WB_LSU = 1;

    core_pkg::fu_vec_t fu_valid;
    core_pkg::fu_vec_t fu_ready;

    // One-hot valid towards the selected unit
    always_comb begin
        for (int u = 0; u < `NB_FU; u++) begin
            fu_valid[u] = valid_i && (fu_i == core_pkg::fu_t'(u));
        end
    end

    fu_alu u_fu_alu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (fu_valid[core_pkg::FU_ALU]),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .imm_i    (imm_i),
        .rd_i     (rd_i),
        .valid_o  (wb_valid_o[WB_ALU]),
        .rd_o     (wb_rd_o[WB_ALU]),
        .result_o (wb_data_o[WB_ALU])
    );
    // ALU never stalls
    assign fu_ready[core_pkg::FU_ALU] = 1'b1;

    fu_lsu u_fu_lsu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (fu_valid[core_pkg::FU_LSU]),
        .ready_o     (fu_ready[core_pkg::FU_LSU]),
        .op_i        (op_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .rd_i        (rd_i),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_be_o    (mem_be_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .valid_o     (wb_valid_o[WB_LSU]),
        .rd_o        (wb_rd_o[WB_LSU]),
        .result_o    (wb_data_o[WB_LSU])
    );

    // Multiply and branch slots are stubs, never ready
    for (genvar g = 0; g < `NB_FU; g++) begin : g_stub
        if (g != int'(core_pkg::FU_ALU) && g != int'(core_pkg::FU_LSU)) begin : g_off
            assign fu_ready[g] = 1'b0;
        end
    end

    assign ready_o = fu_ready;

    // Issue never targets a stub unit
    a_no_stub_issue: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(fu_valid[core_pkg::FU_MUL] || fu_valid[core_pkg::FU_BR]));

endmodule
